//--- dataPath.f
+incdir+include
src/dataPathPkg.sv
src/selectEncode.sv
src/regFile.sv
src/busRegs.sv
src/alu.sv
src/memUnit.sv
src/dataPath.sv
verif/dataPathTb.sv

//--- Makefile
LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f dataPath.f --top-module dataPathTb -Mdir obj_dir

run: compile
	./obj_dir/VdataPathTb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Finished with errors" $(LOG) || ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

//--- verif/dataPathTb.sv
// Directed testbench for the datapath with LFSR operands, watchdog and bus checks
`timescale 1ns/1ps
`include "dataPath_defs.svh"

module dataPathTb
   import dataPathPkg::*;
();

   localparam int clkPeriod = 100;
   localparam int numTests  = 6;
   localparam int mulCycles = 33;
   // No test needs more than eight multiply-length waits
   localparam int watchdogNs = numTests * 8 * (mulCycles + 6) * clkPeriod;
   localparam ctrlWord idle = '0;

   logic               Clock;
   logic               arstN;
   ctrlWord            ctrl;
   aluOp               op;
   logic [`WORD_W-1:0] extData;
   logic [`WORD_W-1:0] busData;
   logic               aluDone;
   logic               memDone;
   logic [31:0]        lfsr = 32'h8027_9f5d;

   dataPath i_dut (.*);

   always #(clkPeriod / 2) Clock = ~Clock;

   task automatic abortRun();
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
   endtask

   initial begin
      #(watchdogNs);
      $display("Watchdog expired before the tests finished");
      abortRun();
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic randomWord(output logic [31:0] w);
      w = '0;
      for (int i = 0; i < 32; i++) begin
         lfsr = lfsrStep(lfsr);
         w = {w[30:0], lfsr[0]};
      end
   endtask

   // st opcode followed by ra, rb and the 19-bit constant
   function automatic logic [31:0] stInstr(input logic [3:0] ra, rb, input logic [18:0] c);
      return {5'd3, ra, rb, c};
   endfunction

   function automatic logic [31:0] aluExpect(input aluOp o, input logic [31:0] a, b);
      case (o)
         opAdd:   return a + b;
         opSub:   return a - b;
         opAnd:   return a & b;
         opOr:    return a | b;
         opShl:   return a << b[4:0];
         opShr:   return a >> b[4:0];
         opNeg:   return 32'd0 - b;
         opNot:   return ~b;
         default: return '0;
      endcase
   endfunction

   task automatic drive(input ctrlWord w, input logic [31:0] d = '0);
      @(posedge Clock);
      ctrl    <= w;
      extData <= d;
   endtask

   task automatic checkBus(input logic [31:0] expected);
      @(negedge Clock);
      assert (busData === expected) else begin
         $display("** Error at %0d ns: busData = 0x%08h, expected 0x%08h",
                  $time, busData, expected);
         abortRun();
      end
   endtask

   // Holds a control word until the selected done pulse shows
   task automatic waitDone(input logic forMem, input ctrlWord hold, input int latency);
      int cycles = 0;
      drive(hold);
      do begin
         @(negedge Clock);
         cycles++;
         if (cycles > mulCycles + 4) begin
            $display("Timed out waiting for %s", forMem ? "memDone" : "aluDone");
            abortRun();
         end
      end while (!(forMem ? memDone : aluDone));
      // Latency counts the cycles after the request cycle
      assert (cycles == latency) else begin
         $display("** Error at %0d ns: %s latency = %0d cycles, expected %0d",
                  $time, forMem ? "memDone" : "aluDone", cycles, latency);
         abortRun();
      end
      // Done is a single-cycle pulse
      @(negedge Clock);
      assert (!(forMem ? memDone : aluDone)) else begin
         $display("%s stayed high for more than one cycle", forMem ? "memDone" : "aluDone");
         abortRun();
      end
   endtask

   task automatic writeReg(input logic [3:0] idx, input logic [31:0] value);
      drive(ctrlWord'{extOut: 1'b1, irIn: 1'b1, default: 1'b0}, stInstr(idx, 4'd0, 19'd0));
      drive(ctrlWord'{extOut: 1'b1, rIn: 1'b1, gra: 1'b1, default: 1'b0}, value);
   endtask

   task automatic writeMem(input logic [8:0] addr, input logic [31:0] data);
      drive(ctrlWord'{extOut: 1'b1, marIn: 1'b1, default: 1'b0}, 32'(addr));
      drive(ctrlWord'{extOut: 1'b1, mdrIn: 1'b1, default: 1'b0}, data);
      drive(ctrlWord'{write: 1'b1, default: 1'b0});
      waitDone(1'b1, idle, 1);
   endtask

   task automatic checkMem(input logic [8:0] addr, input logic [31:0] expected);
      drive(ctrlWord'{extOut: 1'b1, marIn: 1'b1, default: 1'b0}, 32'(addr));
      drive(ctrlWord'{read: 1'b1, default: 1'b0});
      waitDone(1'b1, idle, 1);
      drive(ctrlWord'{mdrOut: 1'b1, default: 1'b0});
      checkBus(expected);
   endtask

   // RY takes a and the bus carries b during the start cycle
   task automatic runAlu(input aluOp o, input logic [31:0] a, b);
      drive(ctrlWord'{extOut: 1'b1, ryIn: 1'b1, default: 1'b0}, a);
      drive(ctrlWord'{extOut: 1'b1, start: 1'b1, rzIn: 1'b1, default: 1'b0}, b);
      op <= o;
      waitDone(1'b0, ctrlWord'{rzIn: 1'b1, default: 1'b0}, (o == opMul) ? mulCycles : 1);
   endtask

   // T0 to T2 of the instruction fetch
   task automatic fetch(input logic [8:0] addr, input logic [31:0] word);
      writeMem(addr, word);
      drive(ctrlWord'{extOut: 1'b1, pcIn: 1'b1, default: 1'b0}, 32'(addr));
      drive(ctrlWord'{pcOut: 1'b1, marIn: 1'b1, incPc: 1'b1, default: 1'b0});
      drive(ctrlWord'{read: 1'b1, default: 1'b0});
      waitDone(1'b1, idle, 1);
      drive(ctrlWord'{mdrOut: 1'b1, irIn: 1'b1, default: 1'b0});
   endtask

   task automatic regTest();
      logic [31:0] vals [4];
      logic [3:0]  idx [4] = '{4'd0, 4'd3, 4'd7, 4'd15};
      for (int k = 0; k < 4; k++) begin
         randomWord(vals[k]);
         writeReg(idx[k], vals[k]);
      end
      for (int k = 0; k < 4; k++) begin
         drive(ctrlWord'{extOut: 1'b1, irIn: 1'b1, default: 1'b0}, stInstr(idx[k], 4'd0, 19'd0));
         drive(ctrlWord'{rOut: 1'b1, gra: 1'b1, default: 1'b0});
         checkBus(vals[k]);
      end
      // R0 as a base address reads zero although it holds a value
      drive(ctrlWord'{baOut: 1'b1, grb: 1'b1, default: 1'b0});
      checkBus('0);
   endtask

   task automatic aluTest();
      logic [31:0] a;
      logic [31:0] b;
      for (int k = 0; k < 8; k++) begin
         randomWord(a);
         randomWord(b);
         runAlu(aluOp'(4'(k)), a, b);
         drive(ctrlWord'{rzLoOut: 1'b1, default: 1'b0});
         checkBus(aluExpect(aluOp'(4'(k)), a, b));
         drive(ctrlWord'{rzHiOut: 1'b1, default: 1'b0});
         checkBus('0);
      end
   endtask

   task automatic mulTest();
      logic [31:0]        a;
      logic [31:0]        b;
      logic signed [63:0] prod;
      for (int k = 0; k < 3; k++) begin
         randomWord(a);
         randomWord(b);
         prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
         runAlu(opMul, a, b);
         drive(ctrlWord'{rzLoOut: 1'b1, default: 1'b0});
         checkBus(prod[31:0]);
         drive(ctrlWord'{rzHiOut: 1'b1, default: 1'b0});
         checkBus(prod[63:32]);
      end
   endtask

   task automatic memTest();
      logic [31:0] data [4];
      logic [8:0]  addr [4];
      logic [31:0] r;
      for (int k = 0; k < 4; k++) begin
         randomWord(r);
         randomWord(data[k]);
         addr[k] = {r[8:2], 2'(k)};
         writeMem(addr[k], data[k]);
      end
      for (int k = 0; k < 4; k++) begin
         checkMem(addr[k], data[k]);
      end
   endtask

   task automatic pcIrTest();
      logic [31:0] v;
      logic [31:0] word;
      randomWord(v);
      randomWord(word);
      drive(ctrlWord'{extOut: 1'b1, pcIn: 1'b1, default: 1'b0}, v);
      drive(ctrlWord'{incPc: 1'b1, default: 1'b0});
      drive(ctrlWord'{pcOut: 1'b1, default: 1'b0});
      checkBus(v + 32'd1);
      fetch(v[8:0], word);
      drive(ctrlWord'{irOut: 1'b1, default: 1'b0});
      checkBus(word);
      drive(ctrlWord'{pcOut: 1'b1, default: 1'b0});
      checkBus(32'(v[8:0]) + 32'd1);
   endtask

   // st ra, c(rb) through T3 to T7 with R0 as zero base when useBase is set
   task automatic storeOffset(input logic useBase);
      logic [31:0] raVal;
      logic [31:0] rbVal;
      logic [31:0] r;
      logic [3:0]  raIdx;
      logic [3:0]  rbIdx;
      logic [18:0] c;
      logic [31:0] addrExp;
      logic [8:0]  target;
      ctrlWord     t3;
      randomWord(raVal);
      randomWord(rbVal);
      randomWord(r);
      raIdx = {1'b1, r[2:0]};
      rbIdx = useBase ? 4'd0 : {1'b0, r[5:3] | 3'd1};
      c = r[31:13];
      // Effective address is the base plus the sign-extended constant
      addrExp = useBase ? {{13{c[18]}}, c} : rbVal + {{13{c[18]}}, c};
      target = addrExp[8:0];
      writeReg(raIdx, raVal);
      writeReg(rbIdx, rbVal);
      fetch(r[12:4], stInstr(raIdx, rbIdx, c));
      t3 = ctrlWord'{grb: 1'b1, ryIn: 1'b1, default: 1'b0};
      t3.baOut = useBase;
      t3.rOut = !useBase;
      drive(t3);
      drive(ctrlWord'{immOut: 1'b1, start: 1'b1, rzIn: 1'b1, default: 1'b0});
      op <= opAdd;
      waitDone(1'b0, ctrlWord'{rzIn: 1'b1, default: 1'b0}, 1);
      drive(ctrlWord'{rzLoOut: 1'b1, marIn: 1'b1, default: 1'b0});
      checkBus(addrExp);
      drive(ctrlWord'{rOut: 1'b1, gra: 1'b1, mdrIn: 1'b1, default: 1'b0});
      drive(ctrlWord'{write: 1'b1, default: 1'b0});
      waitDone(1'b1, idle, 1);
      checkMem(target, raVal);
   endtask

   initial begin
      Clock   = 1'b0;
      arstN   = 1'b0;
      ctrl    = idle;
      op      = opAdd;
      extData = '0;
      repeat (8) @(posedge Clock);
      arstN <= 1'b1;
      regTest();
      aluTest();
      mulTest();
      memTest();
      pcIrTest();
      storeOffset(1'b0);
      storeOffset(1'b1);
      $display("Finished with no errors");
      $finish;
   end

endmodule

//--- src/dataPath.sv
// Datapath top level tying register, ALU and memory blocks to the shared bus
`timescale 1ns/1ps
`include "dataPath_defs.svh"

module dataPath
   import dataPathPkg::*;
(
   input  logic                     Clock,
   input  logic                     arstN,
   input  ctrlWord                  ctrl,
   input  aluOp                     op,
   input  logic [`WORD_W-1:0]       extData,
   output logic [`WORD_W-1:0]       busData,
   output logic                     aluDone,
   output logic                     memDone
);

   instrFields                ir;
   logic [`REG_IDX_W-1:0]     regIdx;
   logic [`WORD_W-1:0]        immExt;
   logic [`WORD_W-1:0]        rdData;
   logic [`WORD_W-1:0]        mdrData;
   logic [`WORD_W-1:0]        ryData;
   logic [2*`WORD_W-1:0]      aluResult;

   selectEncode uSel (
      .Clock  (Clock),
      .arstN  (arstN),
      .ir     (ir),
      .ctrl   (ctrl),
      .regIdx (regIdx),
      .immExt (immExt)
   );

   regFile uRegs (
      .Clock   (Clock),
      .arstN   (arstN),
      .ctrl    (ctrl),
      .regIdx  (regIdx),
      .busData (busData),
      .rdData  (rdData)
   );

   busRegs uBus (
      .Clock     (Clock),
      .arstN     (arstN),
      .ctrl      (ctrl),
      .rdData    (rdData),
      .immExt    (immExt),
      .mdrData   (mdrData),
      .extData   (extData),
      .aluResult (aluResult),
      .aluDone   (aluDone),
      .busData   (busData),
      .ir        (ir),
      .ryData    (ryData)
   );

   // RY is operand A, the bus is operand B
   alu uAlu (
      .Clock  (Clock),
      .arstN  (arstN),
      .op     (op),
      .start  (ctrl.start),
      .a      (ryData),
      .b      (busData),
      .result (aluResult),
      .done   (aluDone)
   );

   memUnit uMem (
      .Clock   (Clock),
      .arstN   (arstN),
      .ctrl    (ctrl),
      .busData (busData),
      .mdrData (mdrData),
      .memDone (memDone)
   );

endmodule

//--- src/memUnit.sv
// MAR, MDR and word RAM with a one-cycle done pulse per access
`timescale 1ns/1ps
`include "dataPath_defs.svh"

module memUnit
   import dataPathPkg::*;
(
   input  logic                     Clock,
   input  logic                     arstN,
   input  ctrlWord                  ctrl,
   input  logic [`WORD_W-1:0]       busData,
   output logic [`WORD_W-1:0]       mdrData,
   output logic                     memDone
);

   logic [`MEM_AW-1:0] mar;
   logic [`WORD_W-1:0] mem [`MEM_WORDS];

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         mar     <= '0;
         mdrData <= '0;
         memDone <= 1'b0;
      end else begin
         if (ctrl.marIn) mar <= busData[`MEM_AW-1:0];
         // Read data takes precedence over a bus load of MDR
         if (ctrl.read) begin
            mdrData <= mem[mar];
         end else if (ctrl.mdrIn) begin
            mdrData <= busData;
         end
         memDone <= ctrl.read | ctrl.write;
      end
   end

   always_ff @(posedge Clock) begin
      if (ctrl.write) begin
         mem[mar] <= mdrData;
      end
   end

   rdWrExcl: assert property (
      @(posedge Clock) disable iff (!arstN)
      !(ctrl.read && ctrl.write)
   ) else $error("memory read and write in the same cycle");

endmodule

//--- src/alu.sv
// Single-cycle logic and arithmetic unit with iterative signed shift-add multiply
`timescale 1ns/1ps
`include "dataPath_defs.svh"

module alu
   import dataPathPkg::*;
(
   input  logic                     Clock,
   input  logic                     arstN,
   input  aluOp                     op,
   input  logic                     start,
   input  logic [`WORD_W-1:0]       a,
   input  logic [`WORD_W-1:0]       b,
   output logic [2*`WORD_W-1:0]     result,
   output logic                     done
);

   logic                   busy;
   logic [4:0]             count;
   logic [2*`WORD_W-1:0]   mcand;
   logic [2*`WORD_W-1:0]   acc;
   logic [2*`WORD_W-1:0]   accNext;
   logic [`WORD_W-1:0]     mplier;
   logic                   negProd;
   logic [`WORD_W-1:0]     magA;
   logic [`WORD_W-1:0]     magB;
   logic [`WORD_W-1:0]     simpleRes;

   always_comb begin
      case (op)
         opAdd:   simpleRes = a + b;
         opSub:   simpleRes = a - b;
         opAnd:   simpleRes = a & b;
         opOr:    simpleRes = a | b;
         opShl:   simpleRes = a << b[4:0];
         opShr:   simpleRes = a >> b[4:0];
         opNeg:   simpleRes = -b;
         opNot:   simpleRes = ~b;
         default: simpleRes = '0;
      endcase
   end

   // Multiply works on magnitudes, sign is fixed up on the last step
   assign magA = a[`WORD_W-1] ? -a : a;
   assign magB = b[`WORD_W-1] ? -b : b;
   assign accNext = acc + (mplier[0] ? mcand : '0);

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         busy    <= 1'b0;
         count   <= '0;
         mcand   <= '0;
         acc     <= '0;
         mplier  <= '0;
         negProd <= 1'b0;
         result  <= '0;
         done    <= 1'b0;
      end else begin
         done <= 1'b0;
         if (busy) begin
            acc    <= accNext;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            count  <= count + 5'd1;
            // 32nd partial product, done shows 33 cycles after start
            if (count == 5'd31) begin
               busy   <= 1'b0;
               done   <= 1'b1;
               result <= negProd ? -accNext : accNext;
            end
         end else if (start) begin
            if (op == opMul) begin
               busy    <= 1'b1;
               count   <= '0;
               acc     <= '0;
               mcand   <= {{`WORD_W{1'b0}}, magA};
               mplier  <= magB;
               negProd <= a[`WORD_W-1] ^ b[`WORD_W-1];
            end else begin
               result <= {{`WORD_W{1'b0}}, simpleRes};
               done   <= 1'b1;
            end
         end
      end
   end

   // Controller must wait for done before the next request
   noStartBusy: assert property (
      @(posedge Clock) disable iff (!arstN)
      start |-> !busy
   ) else $error("ALU start during multiply");

endmodule

//--- src/busRegs.sv
// PC, IR, RY, RZ, HI and LO registers plus the shared bus multiplexer
`timescale 1ns/1ps
`include "dataPath_defs.svh"

module busRegs
   import dataPathPkg::*;
(
   input  logic                     Clock,
   input  logic                     arstN,
   input  ctrlWord                  ctrl,
   input  logic [`WORD_W-1:0]       rdData,
   input  logic [`WORD_W-1:0]       immExt,
   input  logic [`WORD_W-1:0]       mdrData,
   input  logic [`WORD_W-1:0]       extData,
   input  logic [2*`WORD_W-1:0]     aluResult,
   input  logic                     aluDone,
   output logic [`WORD_W-1:0]       busData,
   output instrFields               ir,
   output logic [`WORD_W-1:0]       ryData
);

   logic [`WORD_W-1:0]   pc;
   logic [2*`WORD_W-1:0] rz;
   logic [`WORD_W-1:0]   hi;
   logic [`WORD_W-1:0]   lo;
   logic [11:0]          srcVec;

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         pc     <= '0;
         ir     <= '0;
         ryData <= '0;
         rz     <= '0;
         hi     <= '0;
         lo     <= '0;
      end else begin
         // A bus load wins over increment
         if (ctrl.pcIn) begin
            pc <= busData;
         end else if (ctrl.incPc) begin
            pc <= pc + `WORD_W'd1;
         end
         if (ctrl.irIn) ir <= busData;
         if (ctrl.ryIn) ryData <= busData;
         if (ctrl.hiIn) hi <= busData;
         if (ctrl.loIn) lo <= busData;
         // Result only lands when the ALU reports it ready
         if (ctrl.rzIn && aluDone) rz <= aluResult;
      end
   end

   assign srcVec = {ctrl.rOut, ctrl.baOut, ctrl.pcOut, ctrl.irOut,
                    ctrl.ryOut, ctrl.rzLoOut, ctrl.rzHiOut, ctrl.hiOut,
                    ctrl.loOut, ctrl.immOut, ctrl.mdrOut, ctrl.extOut};

   // AND-OR mux, idle bus reads zero
   assign busData = ({`WORD_W{ctrl.rOut | ctrl.baOut}} & rdData)
                  | ({`WORD_W{ctrl.pcOut}}            & pc)
                  | ({`WORD_W{ctrl.irOut}}            & ir)
                  | ({`WORD_W{ctrl.ryOut}}            & ryData)
                  | ({`WORD_W{ctrl.rzLoOut}}          & rz[`WORD_W-1:0])
                  | ({`WORD_W{ctrl.rzHiOut}}          & rz[2*`WORD_W-1:`WORD_W])
                  | ({`WORD_W{ctrl.hiOut}}            & hi)
                  | ({`WORD_W{ctrl.loOut}}            & lo)
                  | ({`WORD_W{ctrl.immOut}}           & immExt)
                  | ({`WORD_W{ctrl.mdrOut}}           & mdrData)
                  | ({`WORD_W{ctrl.extOut}}           & extData);

   // Single driver on the bus in any cycle
   busOneSrc: assert property (
      @(posedge Clock) disable iff (!arstN)
      $countones(srcVec) <= 1
   ) else $error("more than one bus source enabled");

endmodule

//--- src/regFile.sv
// General register file with bus write and zero-base read for R0
`timescale 1ns/1ps
`include "dataPath_defs.svh"

module regFile
   import dataPathPkg::*;
(
   input  logic                     Clock,
   input  logic                     arstN,
   input  ctrlWord                  ctrl,
   input  logic [`REG_IDX_W-1:0]    regIdx,
   input  logic [`WORD_W-1:0]       busData,
   output logic [`WORD_W-1:0]       rdData
);

   logic [`WORD_W-1:0] regs [`NUM_REGS];

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (ctrl.rIn) begin
         regs[regIdx] <= busData;
      end
   end

   // Base-address read turns R0 into a constant zero
   always_comb begin
      if (ctrl.baOut && (regIdx == '0)) begin
         rdData = '0;
      end else begin
         rdData = regs[regIdx];
      end
   end

endmodule

//--- src/selectEncode.sv
// Register index select and constant sign extension from the instruction register
`timescale 1ns/1ps
`include "dataPath_defs.svh"

module selectEncode
   import dataPathPkg::*;
(
   input  logic                     Clock,
   input  logic                     arstN,
   input  instrFields               ir,
   input  ctrlWord                  ctrl,
   output logic [`REG_IDX_W-1:0]    regIdx,
   output logic [`WORD_W-1:0]       immExt
);

   logic [`IMM_W-1:0] constField;

   // Pick the register field named by the active select line
   always_comb begin
      if (ctrl.gra) begin
         regIdx = ir.ra;
      end else if (ctrl.grb) begin
         regIdx = ir.rb;
      end else if (ctrl.grc) begin
         regIdx = ir.rc;
      end else begin
         regIdx = '0;
      end
   end

   // 19-bit constant spans rc and the low immediate field
   assign constField = {ir.rc, ir.imm};
   assign immExt = {{(`WORD_W - `IMM_W){constField[`IMM_W-1]}}, constField};

   // Any register file access needs exactly one field select
   selOneHot: assert property (
      @(posedge Clock) disable iff (!arstN)
      (ctrl.rIn || ctrl.rOut || ctrl.baOut) |-> $onehot({ctrl.gra, ctrl.grb, ctrl.grc})
   ) else $error("register access without a single field select");

endmodule

//--- src/dataPathPkg.sv
// Control word struct, ALU operation enum and instruction field view
`include "dataPath_defs.svh"

package dataPathPkg;

   // One control word per cycle, driven by the controller
   typedef struct packed {
      // Bus sources
      logic rOut;
      logic baOut;
      logic pcOut;
      logic irOut;
      logic ryOut;
      logic rzLoOut;
      logic rzHiOut;
      logic hiOut;
      logic loOut;
      logic immOut;
      logic mdrOut;
      logic extOut;
      // Register loads
      logic rIn;
      logic pcIn;
      logic irIn;
      logic ryIn;
      logic rzIn;
      logic hiIn;
      logic loIn;
      logic marIn;
      logic mdrIn;
      // Register field selects
      logic gra;
      logic grb;
      logic grc;
      // Misc
      logic incPc;
      logic read;
      logic write;
      logic start;
   } ctrlWord;

   typedef enum logic [3:0] {
      opAdd = 4'd0,
      opSub = 4'd1,
      opAnd = 4'd2,
      opOr  = 4'd3,
      opShl = 4'd4,
      opShr = 4'd5,
      opNeg = 4'd6,
      opNot = 4'd7,
      opMul = 4'd8
   } aluOp;

   // rc sits on top of imm to form the 19-bit constant
   typedef struct packed {
      logic [`OPC_W-1:0]     opcode;
      logic [`REG_IDX_W-1:0] ra;
      logic [`REG_IDX_W-1:0] rb;
      logic [`REG_IDX_W-1:0] rc;
      logic [`IMM_LO_W-1:0]  imm;
   } instrFields;

endpackage

//--- include/dataPath_defs.svh
// Datapath widths, register count, RAM depth and instruction field widths
`ifndef DATAPATH_DEFS_SVH
`define DATAPATH_DEFS_SVH

// Data and bus width
`define WORD_W 32

// General register file
`define NUM_REGS 16

// RAM depth and address width
`define MEM_WORDS 512
`define MEM_AW 9

// Constant field of the instruction, rc plus the low field
`define IMM_W 19

// Instruction word layout, msb first
// opcode [31:27], ra [26:23], rb [22:19], rc [18:15], imm [14:0]
`define OPC_W 5
`define REG_IDX_W 4
`define IMM_LO_W 15

`endif
